// File: source/grid_clear_consts.svh
`ifndef GRID_CLEAR_CONSTS_SVH
`define GRID_CLEAR_CONSTS_SVH

// cells per row
`define GRID_W 16

// rows in the whole field
`define GRID_ROWS 16

// rows held by each of the two banks
`define BANK_DEPTH 8

// roll count and pass counter widths
`define COUNT_W 9
`define PASS_W 6

`endif

// File: source/grid_clear_pkg.sv
`include "grid_clear_consts.svh"

package grid_clear_pkg;

    typedef logic [`GRID_W-1:0] row_t;
    typedef logic [$clog2(`GRID_ROWS)-1:0] row_addr_t;
    typedef logic [$clog2(`BANK_DEPTH)-1:0] bank_addr_t;
    typedef logic [`COUNT_W-1:0] count_t;
    typedef logic [`PASS_W-1:0] pass_t;

    // staging write from the testbench side
    typedef struct packed {
        logic      staging;
        logic      write_en;
        row_addr_t row_addr;
        row_t      row;
    } load_packet_t;

    typedef enum logic [2:0] {
        idle,
        sync_read,
        exchange,
        prime,
        sweep,
        report
    } sweep_state_t;

endpackage

// File: source/row_bank.sv
`timescale 1ns/100ps
`include "grid_clear_consts.svh"

module row_bank (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           write_en_i,
    input  logic                           read_en_i,
    input  logic [$clog2(`BANK_DEPTH)-1:0] addr_i,
    input  logic [`GRID_W-1:0]             wdata_i,
    output logic [`GRID_W-1:0]             rdata_o
);

    logic [`GRID_W-1:0] rows [`BANK_DEPTH];

    // row storage written straight away
    always_ff @(posedge clock) begin
        if (write_en_i) begin
            rows[addr_i] <= wdata_i;
        end
    end

    // read data appears one cycle after the request and holds until the next read
    always_ff @(posedge clock) begin
        if (reset) begin
            rdata_o <= '0;
        end else if (read_en_i) begin
            rdata_o <= rows[addr_i];
        end
    end

endmodule

// File: source/sweep_machine.sv
`timescale 1ns/100ps
`include "grid_clear_consts.svh"

module sweep_machine #(
    parameter int bank_index = 0
) (
    input  logic                         clock,
    input  logic                         reset,
    input  grid_clear_pkg::load_packet_t load_i,
    input  logic                         start_pass_i,
    input  grid_clear_pkg::row_t         halo_row_i,
    output grid_clear_pkg::row_t         boundary_row_o,
    output logic                         pass_done_o,
    output grid_clear_pkg::count_t       removed_o
);

    import grid_clear_pkg::*;

    localparam int first_row  = bank_index * `BANK_DEPTH;
    localparam int last_local = `BANK_DEPTH - 1;
    // bank 0 faces its last row downward, bank 1 its first row upward
    localparam bank_addr_t facing_row = (bank_index == 0) ? bank_addr_t'(last_local) : '0;

    sweep_state_t state;
    bank_addr_t   row_idx;
    logic         phase;
    count_t       count_q;

    row_t win_above;
    row_t win_cur;
    row_t below_val;
    row_t edge_above;
    row_t edge_below;
    row_t mask;
    row_t boundary_q;
    row_t halo_q;

    logic       load_hit;
    logic       bank_we;
    logic       bank_re;
    bank_addr_t bank_addr;
    row_t       bank_wdata;
    row_t       bank_rdata;

    // rolls with fewer than four of eight neighbours, edges padded with empty cells
    function automatic row_t accessible(input row_t above, input row_t cur, input row_t below);
        logic [`GRID_W+1:0] a_pad;
        logic [`GRID_W+1:0] c_pad;
        logic [`GRID_W+1:0] b_pad;
        logic [3:0]         nbrs;
        row_t               result;
        a_pad = {1'b0, above, 1'b0};
        c_pad = {1'b0, cur, 1'b0};
        b_pad = {1'b0, below, 1'b0};
        for (int j = 0; j < `GRID_W; j++) begin
            nbrs = 4'(a_pad[j]) + 4'(a_pad[j+1]) + 4'(a_pad[j+2])
                 + 4'(c_pad[j]) + 4'(c_pad[j+2])
                 + 4'(b_pad[j]) + 4'(b_pad[j+1]) + 4'(b_pad[j+2]);
            result[j] = cur[j] && (nbrs < 4'd4);
        end
        return result;
    endfunction

    function automatic count_t popcount(input row_t r);
        count_t n;
        n = '0;
        for (int j = 0; j < `GRID_W; j++) begin
            n = n + count_t'(r[j]);
        end
        return n;
    endfunction

    assign load_hit = load_i.staging && load_i.write_en
                   && ((int'(load_i.row_addr) / `BANK_DEPTH) == bank_index);

    // the outer edge beyond row 0 or row 15 is empty
    assign edge_above = (bank_index == 0) ? '0 : halo_q;
    assign edge_below = (bank_index == 0) ? halo_q : '0;
    assign below_val  = (row_idx == bank_addr_t'(last_local)) ? edge_below : bank_rdata;
    assign mask       = accessible(win_above, win_cur, below_val);

    // single port shared by staging loads, boundary read and the sweep
    always_comb begin
        bank_we    = 1'b0;
        bank_re    = 1'b0;
        bank_addr  = '0;
        bank_wdata = win_cur & ~mask;
        if (load_i.staging) begin
            bank_we    = load_hit;
            bank_addr  = bank_addr_t'(int'(load_i.row_addr) - first_row);
            bank_wdata = load_i.row;
        end else begin
            case (state)
                idle: begin
                    bank_re   = start_pass_i;
                    bank_addr = facing_row;
                end
                exchange: begin
                    bank_re   = 1'b1;
                    bank_addr = bank_addr_t'(0);
                end
                prime: begin
                    bank_re   = 1'b1;
                    bank_addr = bank_addr_t'(1);
                end
                sweep: begin
                    if (!phase) begin
                        bank_we   = 1'b1;
                        bank_addr = row_idx;
                    end else begin
                        // fetch the row below the next one, none past the bank end
                        bank_re   = (row_idx < bank_addr_t'(last_local - 1));
                        bank_addr = row_idx + bank_addr_t'(2);
                    end
                end
                default: begin
                    bank_re = 1'b0;
                end
            endcase
        end
    end

    row_bank bank (
        .clock      (clock),
        .reset      (reset),
        .write_en_i (bank_we),
        .read_en_i  (bank_re),
        .addr_i     (bank_addr),
        .wdata_i    (bank_wdata),
        .rdata_o    (bank_rdata)
    );

    always_ff @(posedge clock) begin
        if (reset) begin
            state   <= idle;
            row_idx <= '0;
            phase   <= 1'b0;
            count_q <= '0;
        end else begin
            case (state)
                idle: begin
                    if (start_pass_i) begin
                        state <= sync_read;
                    end
                end
                sync_read: state <= exchange;
                exchange:  state <= prime;
                prime: begin
                    state   <= sweep;
                    row_idx <= '0;
                    phase   <= 1'b0;
                    count_q <= '0;
                end
                sweep: begin
                    if (!phase) begin
                        count_q <= count_q + popcount(mask);
                        if (row_idx == bank_addr_t'(last_local)) begin
                            state <= report;
                        end else begin
                            phase <= 1'b1;
                        end
                    end else begin
                        row_idx <= row_idx + bank_addr_t'(1);
                        phase   <= 1'b0;
                    end
                end
                report:  state <= idle;
                default: state <= idle;
            endcase
        end
    end

    // window keeps the rows as read, so writes never feed back into this pass
    always_ff @(posedge clock) begin
        if (state == sync_read) begin
            boundary_q <= bank_rdata;
        end
        if (state == exchange) begin
            halo_q <= halo_row_i;
        end
        if (state == prime) begin
            win_above <= edge_above;
            win_cur   <= bank_rdata;
        end
        if (state == sweep && !phase) begin
            win_above <= win_cur;
            win_cur   <= below_val;
        end
    end

    assign boundary_row_o = boundary_q;
    assign pass_done_o    = (state == report);
    assign removed_o      = count_q;

endmodule

// File: source/pass_control.sv
`timescale 1ns/100ps
`include "grid_clear_consts.svh"

module pass_control (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   run_i,
    input  logic                   pass_done_a_i,
    input  grid_clear_pkg::count_t removed_a_i,
    input  logic                   pass_done_b_i,
    input  grid_clear_pkg::count_t removed_b_i,
    output logic                   start_pass_o,
    output logic                   busy_o,
    output logic                   done_o,
    output grid_clear_pkg::count_t first_pass_o,
    output grid_clear_pkg::count_t total_o,
    output grid_clear_pkg::pass_t  passes_o
);

    import grid_clear_pkg::*;

    logic   got_a;
    logic   got_b;
    logic   arrived_a;
    logic   arrived_b;
    logic   pass_end;
    count_t held_a;
    count_t held_b;
    count_t count_a;
    count_t count_b;
    count_t pass_sum;
    count_t first_q;
    count_t total_q;
    pass_t  passes_q;
    logic   start_q;
    logic   busy_q;
    logic   done_q;

    // a machine counts as finished on its pulse or once latched earlier
    assign arrived_a = got_a | pass_done_a_i;
    assign arrived_b = got_b | pass_done_b_i;
    assign count_a   = pass_done_a_i ? removed_a_i : held_a;
    assign count_b   = pass_done_b_i ? removed_b_i : held_b;
    assign pass_end  = busy_q && arrived_a && arrived_b;
    assign pass_sum  = count_a + count_b;

    always_ff @(posedge clock) begin
        if (pass_done_a_i) begin
            held_a <= removed_a_i;
        end
        if (pass_done_b_i) begin
            held_b <= removed_b_i;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            got_a    <= 1'b0;
            got_b    <= 1'b0;
            start_q  <= 1'b0;
            busy_q   <= 1'b0;
            done_q   <= 1'b0;
            first_q  <= '0;
            total_q  <= '0;
            passes_q <= '0;
        end else begin
            start_q <= 1'b0;
            if (run_i && !busy_q) begin
                busy_q   <= 1'b1;
                done_q   <= 1'b0;
                start_q  <= 1'b1;
                first_q  <= '0;
                total_q  <= '0;
                passes_q <= '0;
                got_a    <= 1'b0;
                got_b    <= 1'b0;
            end else if (pass_end) begin
                got_a    <= 1'b0;
                got_b    <= 1'b0;
                total_q  <= total_q + pass_sum;
                passes_q <= passes_q + pass_t'(1);
                if (passes_q == '0) begin
                    first_q <= pass_sum;
                end
                // rerun while anything was removed, else finish
                if (pass_sum != '0) begin
                    start_q <= 1'b1;
                end else begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end else begin
                if (pass_done_a_i) begin
                    got_a <= 1'b1;
                end
                if (pass_done_b_i) begin
                    got_b <= 1'b1;
                end
            end
        end
    end

    assign start_pass_o = start_q;
    assign busy_o       = busy_q;
    assign done_o       = done_q;
    assign first_pass_o = first_q;
    assign total_o      = total_q;
    assign passes_o     = passes_q;

endmodule

// File: source/grid_clear_top.sv
`timescale 1ns/100ps
`include "grid_clear_consts.svh"

module grid_clear_top (
    input  logic                         clock,
    input  logic                         reset,
    input  grid_clear_pkg::load_packet_t load_i,
    input  logic                         run_i,
    output logic                         busy_o,
    output logic                         done_o,
    output grid_clear_pkg::count_t       first_pass_o,
    output grid_clear_pkg::count_t       total_o,
    output grid_clear_pkg::pass_t        passes_o
);

    import grid_clear_pkg::*;

    logic   start_pass;
    logic   pass_done_a;
    logic   pass_done_b;
    count_t removed_a;
    count_t removed_b;
    row_t   boundary_a;
    row_t   boundary_b;

    // rows 0 to 7 with row 8 from bank_b as halo
    sweep_machine #(
        .bank_index (0)
    ) bank_a (
        .clock          (clock),
        .reset          (reset),
        .load_i         (load_i),
        .start_pass_i   (start_pass),
        .halo_row_i     (boundary_b),
        .boundary_row_o (boundary_a),
        .pass_done_o    (pass_done_a),
        .removed_o      (removed_a)
    );

    // rows 8 to 15 with row 7 from bank_a as halo
    sweep_machine #(
        .bank_index (1)
    ) bank_b (
        .clock          (clock),
        .reset          (reset),
        .load_i         (load_i),
        .start_pass_i   (start_pass),
        .halo_row_i     (boundary_a),
        .boundary_row_o (boundary_b),
        .pass_done_o    (pass_done_b),
        .removed_o      (removed_b)
    );

    pass_control control (
        .clock         (clock),
        .reset         (reset),
        .run_i         (run_i),
        .pass_done_a_i (pass_done_a),
        .removed_a_i   (removed_a),
        .pass_done_b_i (pass_done_b),
        .removed_b_i   (removed_b),
        .start_pass_o  (start_pass),
        .busy_o        (busy_o),
        .done_o        (done_o),
        .first_pass_o  (first_pass_o),
        .total_o       (total_o),
        .passes_o      (passes_o)
    );

endmodule

// File: testbench/clock_gen.sv
`timescale 1ns/100ps

module clock_gen (
    output logic clock_o,
    output logic reset_o
);

    // reset held over eight rising edges, released on a falling edge
    initial begin
        clock_o = 1'b0;
        reset_o = 1'b1;
        repeat (8) @(posedge clock_o);
        @(negedge clock_o);
        reset_o = 1'b0;
    end

    // 100 ns period
    always #50 clock_o = ~clock_o;

endmodule

// File: testbench/grid_clear_assert.sv
`timescale 1ns/100ps

module grid_clear_assert (
    input logic                   clock,
    input logic                   reset,
    input logic                   run_i,
    input logic                   busy_i,
    input logic                   done_i,
    input grid_clear_pkg::count_t total_i
);

    logic seen_run;

    always_ff @(posedge clock) begin
        if (reset) begin
            seen_run <= 1'b0;
        end else if (run_i) begin
            seen_run <= 1'b1;
        end
    end

    done_busy_exclusive: assert property (@(posedge clock) disable iff (reset)
        !(done_i && busy_i))
        else $error("done and busy are high in the same cycle");

    // done holds until the next run request
    done_holds: assert property (@(posedge clock) disable iff (reset)
        done_i && !run_i |=> done_i)
        else $error("done dropped without a run request");

    total_rises: assert property (@(posedge clock) disable iff (reset)
        busy_i |=> total_i >= $past(total_i))
        else $error("total count decreased during a run");

    quiet_after_reset: assert property (@(posedge clock) disable iff (reset)
        !seen_run |-> !done_i)
        else $error("done raised before any run request");

endmodule

// File: testbench/grid_clear_tb.sv
`timescale 1ns/100ps
`include "grid_clear_consts.svh"

module grid_clear_tb;

    import grid_clear_pkg::*;

    localparam int max_cases = 16;
    // 20 passes of at most 40 cycles each
    localparam int pass_budget = 20 * 40;

    logic         clock;
    logic         reset;
    load_packet_t load;
    logic         run;
    logic         busy;
    logic         done;
    count_t       first_pass;
    count_t       total;
    pass_t        passes;

    row_t case_rows [max_cases][`GRID_ROWS];
    int   exp_first [max_cases];
    int   exp_total [max_cases];
    int   exp_passes [max_cases];
    int   n_cases;
    logic cases_ready;
    int   errors;
    int   checks;

    // grid under test and the model's working copies
    row_t grid_rows [`GRID_ROWS];
    row_t work [`GRID_ROWS];
    row_t kept [`GRID_ROWS];

    clock_gen clocks (
        .clock_o (clock),
        .reset_o (reset)
    );

    grid_clear_top grid_clear_top_i (
        .clock        (clock),
        .reset        (reset),
        .load_i       (load),
        .run_i        (run),
        .busy_o       (busy),
        .done_o       (done),
        .first_pass_o (first_pass),
        .total_o      (total),
        .passes_o     (passes)
    );

    bind grid_clear_top grid_clear_assert assertions (
        .clock   (clock),
        .reset   (reset),
        .run_i   (run_i),
        .busy_i  (busy_o),
        .done_i  (done_o),
        .total_i (total_o)
    );

    // each case is 16 hex rows, then first pass count, total and passes in decimal
    task automatic read_patterns();
        int   fd;
        int   code;
        row_t value;
        int   e_first;
        int   e_total;
        int   e_passes;
        fd = $fopen("testbench/grid_clear_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open testbench/grid_clear_patterns.txt");
            errors++;
            return;
        end
        code = $fscanf(fd, "%h", value);
        while (code == 1 && n_cases < max_cases) begin
            case_rows[n_cases][0] = value;
            for (int r = 1; r < `GRID_ROWS; r++) begin
                code = $fscanf(fd, "%h", value);
                case_rows[n_cases][r] = value;
            end
            code = $fscanf(fd, "%d %d %d", e_first, e_total, e_passes);
            if (code != 3) begin
                $display("patterns file ends in the middle of case %0d", n_cases);
                errors++;
                break;
            end
            exp_first[n_cases]  = e_first;
            exp_total[n_cases]  = e_total;
            exp_passes[n_cases] = e_passes;
            n_cases++;
            code = $fscanf(fd, "%h", value);
        end
        $fclose(fd);
    endtask

    function automatic int cell_at(input int r, input int c);
        return (r < 0 || r >= `GRID_ROWS || c < 0 || c >= `GRID_W) ? 0 : int'(work[r][c]);
    endfunction

    // peel the grid pass by pass with each pass judged on the grid at its start
    task automatic model_grid(output int m_first, output int m_total, output int m_passes);
        int removed;
        int nbrs;
        for (int r = 0; r < `GRID_ROWS; r++) begin
            work[r] = grid_rows[r];
        end
        m_first  = 0;
        m_total  = 0;
        m_passes = 0;
        removed  = 1;
        while (removed != 0) begin
            removed = 0;
            for (int r = 0; r < `GRID_ROWS; r++) begin
                for (int c = 0; c < `GRID_W; c++) begin
                    nbrs = cell_at(r - 1, c - 1) + cell_at(r - 1, c) + cell_at(r - 1, c + 1)
                         + cell_at(r, c - 1) + cell_at(r, c + 1)
                         + cell_at(r + 1, c - 1) + cell_at(r + 1, c) + cell_at(r + 1, c + 1);
                    kept[r][c] = work[r][c] && (nbrs >= 4);
                    if (work[r][c] && nbrs < 4) begin
                        removed++;
                    end
                end
            end
            for (int r = 0; r < `GRID_ROWS; r++) begin
                work[r] = kept[r];
            end
            m_passes++;
            if (m_passes == 1) begin
                m_first = removed;
            end
            m_total += removed;
        end
    endtask

    task automatic load_grid();
        for (int r = 0; r < `GRID_ROWS; r++) begin
            @(negedge clock);
            load.staging  = 1'b1;
            load.write_en = 1'b1;
            load.row_addr = row_addr_t'(r);
            load.row      = grid_rows[r];
        end
        @(negedge clock);
        load = '0;
    endtask

    task automatic run_and_check(input int id, input int e_first, input int e_total,
                                 input int e_passes);
        @(negedge clock);
        run = 1'b1;
        @(negedge clock);
        run = 1'b0;
        checks++;
        if (!busy || done) begin
            errors++;
            $display("FAILED at %0d ns: case %0d did not start, busy %0b done %0b",
                     $time, id, busy, done);
        end
        while (!done) begin
            @(negedge clock);
        end
        checks += 4;
        if (int'(first_pass) != e_first) begin
            errors++;
            $display("FAILED at %0d ns: case %0d first pass count %0d, expected %0d",
                     $time, id, first_pass, e_first);
        end
        if (int'(total) != e_total) begin
            errors++;
            $display("FAILED at %0d ns: case %0d total %0d, expected %0d",
                     $time, id, total, e_total);
        end
        if (int'(passes) != e_passes) begin
            errors++;
            $display("FAILED at %0d ns: case %0d passes %0d, expected %0d",
                     $time, id, passes, e_passes);
        end
        if (busy) begin
            errors++;
            $display("FAILED at %0d ns: case %0d busy still high with done", $time, id);
        end
    endtask

    initial begin
        int m_first;
        int m_total;
        int m_passes;
        load        = '0;
        run         = 1'b0;
        errors      = 0;
        checks      = 0;
        n_cases     = 0;
        cases_ready = 1'b0;
        void'($urandom(97));
        read_patterns();
        if (n_cases == 0) begin
            $display("no test cases were read from the patterns file");
            errors++;
        end
        cases_ready = 1'b1;
        @(negedge reset);

        for (int i = 0; i < n_cases; i++) begin
            for (int r = 0; r < `GRID_ROWS; r++) begin
                grid_rows[r] = case_rows[i][r];
            end
            load_grid();
            run_and_check(i, exp_first[i], exp_total[i], exp_passes[i]);
        end

        // random grid checked against the local model
        for (int r = 0; r < `GRID_ROWS; r++) begin
            grid_rows[r] = row_t'($urandom);
        end
        model_grid(m_first, m_total, m_passes);
        load_grid();
        run_and_check(n_cases, m_first, m_total, m_passes);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin : watchdog
        int limit;
        wait (cases_ready);
        limit = (n_cases + 1) * (pass_budget + 2 * `GRID_ROWS) + 16;
        repeat (limit) @(posedge clock);
        $display("timeout: the run hung, no final result after %0d clock cycles", limit);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: grid_clear.f
+incdir+source
source/grid_clear_pkg.sv
source/row_bank.sv
source/sweep_machine.sv
source/pass_control.sv
source/grid_clear_top.sv
testbench/clock_gen.sv
testbench/grid_clear_assert.sv
testbench/grid_clear_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the grid clearing testbench with Verilator, run it and check the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module grid_clear_tb -o grid_clear_sim -f grid_clear.f

./obj_dir/grid_clear_sim | tee sim.log

if grep -qx "Simulation completed successfully" sim.log; then
    echo "PASS: see sim.log"
else
    echo "FAIL: see sim.log"
    exit 1
fi

// File: testbench/grid_clear_patterns.txt
0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000
0 0 1
ffff ffff ffff ffff ffff ffff ffff ffff
ffff ffff ffff ffff ffff ffff ffff ffff
4 4 2
0000 0000 0000 0000 0000 0000 0000 00f0
00f0 0000 0000 0000 0000 0000 0000 0000
4 8 3
0000 0000 000e 000e 000e 0000 0000 0000
0000 0000 0000 1c00 1c00 1c00 0000 0000
8 18 4
ffff 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 ffff
32 32 2
0000 0000 0000 0000 0000 0000 00f0 00f0
00f0 00f0 0000 0000 0000 0000 0000 0000
4 4 2
